/* cache_l2.f */
+incdir+.
cache_l2_pkg.sv
l2_line_store.sv
l2_lookup.sv
l2_miss_fsm.sv
cache_l2.sv
cache_l2_tb.sv

/* cache_l2_tb.sv */
`timescale 1ns/1ps
`include "cache_l2_params.svh"

module cache_l2_tb
    import cache_l2_pkg::*;
;

    localparam int READY_TIMEOUT = 64;
    localparam int MODEL_LINES   = 512;
    localparam int RANDOM_OPS    = 300;

    logic                           clk;
    logic                           proc_reset;
    l2_req_t                        req;
    logic                           ready;
    logic [`L2_WORD_W-1:0]          rdata;
    l2_mem_req_t                    mem_req;
    logic                           mem_ready;
    l2_line_u                       mem_rdata;

    integer                         seed = 32'h7110;
    int                             error_count = 0;
    int                             read_checks = 0;

    // memory traffic seen by the backing model
    int                             mem_read_cnt = 0;
    int                             mem_write_cnt = 0;
    logic [`L2_MEM_ADDR_W-1:0]      last_read_addr;
    logic [`L2_MEM_ADDR_W-1:0]      last_write_addr;

    // backing memory over the window of tags 0..7
    l2_line_u                       mem_lines [MODEL_LINES];

    // golden word map over the same window
    logic [`L2_WORD_W-1:0]          golden [MODEL_LINES*`L2_WORDS];
    logic                           golden_written [MODEL_LINES*`L2_WORDS];
    logic [`L2_WORD_W-1:0]          expected_word;

    cache_l2 dut_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .req        (req),
        .ready      (ready),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // initial memory contents
    // the odd multiplier keeps every word address distinct
    function automatic logic [`L2_WORD_W-1:0] init_word(input logic [`L2_ADDR_W-1:0] waddr);
        logic [31:0] wide;
        wide = {2'b00, waddr};
        return (wide * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // expected value of a word read
    function automatic logic [`L2_WORD_W-1:0] ref_read(input logic [`L2_ADDR_W-1:0] waddr);
        if (golden_written[waddr[10:0]]) begin
            return golden[waddr[10:0]];
        end else begin
            return init_word(waddr);
        end
    endfunction

    function automatic l2_addr_t make_addr(input int tag, input int index, input int offset);
        l2_addr_t a;
        a.tag    = `L2_TAG_W'(tag);
        a.index  = `L2_INDEX_W'(index);
        a.offset = `L2_OFFSET_W'(offset);
        return a;
    endfunction

    task automatic finish_run();
        $display("summary: %0d reads compared, %0d errors", read_checks, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // drive one request and hold it until ready
    task automatic issue_access(input logic is_write, input l2_addr_t addr,
                                input logic [`L2_WORD_W-1:0] wdata);
        int   cycles;
        logic got;
        req.read  = !is_write;
        req.write = is_write;
        req.addr  = addr;
        req.wdata = wdata;
        cycles    = 0;
        got       = 1'b0;
        while (!got && cycles < READY_TIMEOUT) begin
            @(posedge clk);
            got = (ready === 1'b1);
            cycles++;
        end
        if (!got) begin
            error_count++;
            $display("timeout: ready never came for the request at address %h", addr);
            finish_run();
        end else begin
            #1;
            req = '0;
        end
    endtask

    // compare completed reads and fold completed writes into the golden map
    always @(posedge clk) begin
        if (!proc_reset && ready === 1'b1) begin
            if (req.read) begin
                expected_word = ref_read(req.addr);
                read_checks++;
                if (rdata !== expected_word) begin
                    error_count++;
                    $display("[FAIL] rdata addr %h: got %h, expected %h",
                             req.addr, rdata, expected_word);
                end
            end else if (req.write) begin
                golden[req.addr[10:0]]         = req.wdata;
                golden_written[req.addr[10:0]] = 1'b1;
            end
        end
    end

    // backing memory answers after 1 to 4 cycles
    initial begin
        logic [31:0]                rnd;
        logic [`L2_MEM_ADDR_W-1:0]  laddr;
        logic [`L2_WORD_W-1:0]      exp_word;
        int                         lat;
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < MODEL_LINES; i++) begin
            for (int w = 0; w < `L2_WORDS; w++) begin
                mem_lines[i].words[w] = init_word({i[`L2_MEM_ADDR_W-1:0], w[1:0]});
                golden_written[i*`L2_WORDS+w] = 1'b0;
            end
        end
        forever begin
            @(posedge clk);
            if (!proc_reset && (mem_req.read === 1'b1 || mem_req.write === 1'b1)) begin
                laddr = mem_req.addr;
                rnd   = $random(seed);
                lat   = 1 + rnd[1:0];
                repeat (lat - 1) @(posedge clk);
                #1;
                if (laddr[`L2_MEM_ADDR_W-1:9] != '0) begin
                    error_count++;
                    $display("memory request at line address %h is outside the model", laddr);
                end
                if (mem_req.write) begin
                    mem_write_cnt++;
                    last_write_addr = laddr;
                    // victim data must match what L1 last wrote
                    for (int w = 0; w < `L2_WORDS; w++) begin
                        exp_word = ref_read({laddr, w[1:0]});
                        if (mem_req.wdata.words[w] !== exp_word) begin
                            error_count++;
                            $display("[FAIL] mem_req.wdata line %h word %0d: got %h, expected %h",
                                     laddr, w, mem_req.wdata.words[w], exp_word);
                        end
                    end
                    mem_lines[laddr[8:0]] = mem_req.wdata;
                end else begin
                    mem_read_cnt++;
                    last_read_addr = laddr;
                    mem_rdata = mem_lines[laddr[8:0]];
                end
                mem_ready = 1'b1;
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
            end
        end
    end

    initial begin
        l2_addr_t    a;
        l2_addr_t    b;
        logic [31:0] rnd;
        logic [31:0] wd;
        int          reads_before;
        int          writes_before;
        proc_reset = 1'b1;
        req        = '0;
        repeat (8) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        // idle outputs after reset
        @(posedge clk);
        if (ready !== 1'b0 || mem_req.read !== 1'b0 || mem_req.write !== 1'b0) begin
            error_count++;
            $display("[FAIL] idle after reset: ready %h, mem_req.read %h, mem_req.write %h",
                     ready, mem_req.read, mem_req.write);
        end
        #1;

        // untouched address refills from memory
        a = make_addr(6, 9, 1);
        reads_before = mem_read_cnt;
        issue_access(1'b0, a, '0);
        if (mem_read_cnt != reads_before + 1) begin
            error_count++;
            $display("untouched read did not raise exactly one memory read");
        end
        if (last_read_addr !== {a.tag, a.index}) begin
            error_count++;
            $display("[FAIL] mem_req.addr: got %h, expected %h", last_read_addr, {a.tag, a.index});
        end

        // write hit and read back followed by a second word of the same line
        reads_before  = mem_read_cnt;
        writes_before = mem_write_cnt;
        issue_access(1'b1, a, 32'hcafe_0123);
        issue_access(1'b0, a, '0);
        issue_access(1'b0, make_addr(6, 9, 3), '0);
        if (mem_read_cnt != reads_before || mem_write_cnt != writes_before) begin
            error_count++;
            $display("hits in a resident line caused memory traffic");
        end

        // dirty victim goes back to memory before the conflicting refill
        a = make_addr(1, 5, 2);
        b = make_addr(3, 5, 0);
        issue_access(1'b1, a, 32'h1357_9bdf);
        writes_before = mem_write_cnt;
        issue_access(1'b0, b, '0);
        if (mem_write_cnt != writes_before + 1) begin
            error_count++;
            $display("conflicting read did not write the dirty line back exactly once");
        end
        if (last_write_addr !== {a.tag, a.index}) begin
            error_count++;
            $display("[FAIL] mem_req.addr: got %h, expected %h",
                     last_write_addr, {a.tag, a.index});
        end
        issue_access(1'b0, a, '0);

        // random mix over 4 tags and 8 indexes
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            a   = make_addr(int'(rnd[6:5]), int'(rnd[4:2]), int'(rnd[1:0]));
            issue_access(rnd[7], a, wd);
        end

        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

/* cache_l2.sv */
`timescale 1ns/1ps
`include "cache_l2_params.svh"

module cache_l2
    import cache_l2_pkg::*;
(
    input  logic                    clk,
    input  logic                    proc_reset,
    // L1 side
    input  l2_req_t                 req,
    output logic                    ready,
    output logic [`L2_WORD_W-1:0]   rdata,
    // memory side
    output l2_mem_req_t             mem_req,
    input  logic                    mem_ready,
    input  l2_line_u                mem_rdata
);

    logic [`L2_INDEX_W-1:0]     index;
    l2_meta_t                   meta;
    l2_line_u                   line;
    logic                       hit;
    l2_line_u                   merged_line;
    logic [`L2_MEM_ADDR_W-1:0]  victim_addr;
    logic                       wr_en;
    l2_meta_t                   wr_meta;
    l2_line_u                   wr_line;

    // tag, state and data arrays
    l2_line_store store_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .rd_index   (index),
        .rd_meta    (meta),
        .rd_line    (line),
        .wr_en      (wr_en),
        .wr_meta    (wr_meta),
        .wr_line    (wr_line)
    );

    // hit check and word handling for the held request
    l2_lookup lookup_i (
        .req         (req),
        .meta        (meta),
        .line        (line),
        .index       (index),
        .hit         (hit),
        .rdata       (rdata),
        .merged_line (merged_line),
        .victim_addr (victim_addr)
    );

    // hit completion, write-back and refill
    l2_miss_fsm fsm_i (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .req         (req),
        .hit         (hit),
        .meta        (meta),
        .line        (line),
        .merged_line (merged_line),
        .victim_addr (victim_addr),
        .ready       (ready),
        .wr_en       (wr_en),
        .wr_meta     (wr_meta),
        .wr_line     (wr_line),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* l2_miss_fsm.sv */
`timescale 1ns/1ps
`include "cache_l2_params.svh"

module l2_miss_fsm
    import cache_l2_pkg::*;
(
    input  logic                        clk,
    input  logic                        proc_reset,
    input  l2_req_t                     req,
    input  logic                        hit,
    input  l2_meta_t                    meta,
    input  l2_line_u                    line,
    input  l2_line_u                    merged_line,
    input  logic [`L2_MEM_ADDR_W-1:0]   victim_addr,
    output logic                        ready,
    output logic                        wr_en,
    output l2_meta_t                    wr_meta,
    output l2_line_u                    wr_line,
    output l2_mem_req_t                 mem_req,
    input  logic                        mem_ready,
    input  l2_line_u                    mem_rdata
);

    localparam logic [1:0] IDLE      = 2'd0;
    localparam logic [1:0] WRITEBACK = 2'd1;
    localparam logic [1:0] REFILL    = 2'd2;

    logic [1:0]  state_q;
    logic [1:0]  state_d;
    l2_mem_req_t mem_req_q;
    l2_mem_req_t mem_req_d;
    logic        req_active;

    assign req_active = req.read || req.write;
    assign mem_req    = mem_req_q;

    always_comb begin
        state_d   = state_q;
        mem_req_d = mem_req_q;
        ready     = 1'b0;
        wr_en     = 1'b0;
        wr_meta   = meta;
        wr_line   = line;

        case (state_q)
            IDLE: begin
                if (req_active && hit) begin
                    ready = 1'b1;
                    // write hit just marks the line dirty
                    if (req.write) begin
                        wr_en         = 1'b1;
                        wr_meta.dirty = 1'b1;
                        wr_line       = merged_line;
                    end
                end else if (req_active) begin
                    if (meta.valid && meta.dirty) begin
                        // victim goes out first
                        mem_req_d.read  = 1'b0;
                        mem_req_d.write = 1'b1;
                        mem_req_d.addr  = victim_addr;
                        mem_req_d.wdata = line;
                        state_d         = WRITEBACK;
                    end else begin
                        mem_req_d.read  = 1'b1;
                        mem_req_d.write = 1'b0;
                        mem_req_d.addr  = {req.addr.tag, req.addr.index};
                        state_d         = REFILL;
                    end
                end
            end

            WRITEBACK: begin
                if (mem_ready) begin
                    // victim now clean, idle sees a clean miss next
                    wr_en           = 1'b1;
                    wr_meta.dirty   = 1'b0;
                    mem_req_d.write = 1'b0;
                    state_d         = IDLE;
                end
            end

            REFILL: begin
                if (mem_ready) begin
                    // install valid and clean, request hits next cycle
                    wr_en          = 1'b1;
                    wr_meta.valid  = 1'b1;
                    wr_meta.dirty  = 1'b0;
                    wr_meta.tag    = req.addr.tag;
                    wr_line        = mem_rdata;
                    mem_req_d.read = 1'b0;
                    state_d        = IDLE;
                end
            end

            default: begin
                state_d         = IDLE;
                mem_req_d.read  = 1'b0;
                mem_req_d.write = 1'b0;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q         <= IDLE;
            mem_req_q.read  <= 1'b0;
            mem_req_q.write <= 1'b0;
        end else begin
            state_q         <= state_d;
            mem_req_q.read  <= mem_req_d.read;
            mem_req_q.write <= mem_req_d.write;
        end
    end

    // memory request payload
    always_ff @(posedge clk) begin
        mem_req_q.addr  <= mem_req_d.addr;
        mem_req_q.wdata <= mem_req_d.wdata;
    end

endmodule

/* l2_lookup.sv */
`timescale 1ns/1ps
`include "cache_l2_params.svh"

module l2_lookup
    import cache_l2_pkg::*;
(
    input  l2_req_t                     req,
    input  l2_meta_t                    meta,
    input  l2_line_u                    line,
    output logic [`L2_INDEX_W-1:0]      index,
    output logic                        hit,
    output logic [`L2_WORD_W-1:0]       rdata,
    output l2_line_u                    merged_line,
    output logic [`L2_MEM_ADDR_W-1:0]   victim_addr
);

    logic tag_match;

    assign index     = req.addr.index;
    assign tag_match = (meta.tag == req.addr.tag);

    // a hit needs a valid line with the same tag
    assign hit = meta.valid && tag_match;

    // word select for reads
    assign rdata = line.words[req.addr.offset];

    // write word dropped into the stored line
    always_comb begin
        merged_line = line;
        merged_line.words[req.addr.offset] = req.wdata;
    end

    // line address of whatever currently sits at this index
    assign victim_addr = {meta.tag, req.addr.index};

endmodule

/* l2_line_store.sv */
`timescale 1ns/1ps
`include "cache_l2_params.svh"

module l2_line_store
    import cache_l2_pkg::*;
(
    input  logic                    clk,
    input  logic                    proc_reset,
    input  logic [`L2_INDEX_W-1:0]  rd_index,
    output l2_meta_t                rd_meta,
    output l2_line_u                rd_line,
    input  logic                    wr_en,
    input  l2_meta_t                wr_meta,
    input  l2_line_u                wr_line
);

    // state bits, one per line
    logic [`L2_LINES-1:0] valid_q;
    logic [`L2_LINES-1:0] dirty_q;

    // tag and data arrays
    logic [`L2_TAG_W-1:0] tag_q [`L2_LINES];
    l2_line_u             data_q [`L2_LINES];

    // combinational read at the request index
    assign rd_meta.valid = valid_q[rd_index];
    assign rd_meta.dirty = dirty_q[rd_index];
    assign rd_meta.tag   = tag_q[rd_index];
    assign rd_line       = data_q[rd_index];

    // reset invalidates every line at once
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[rd_index] <= wr_meta.valid;
            dirty_q[rd_index] <= wr_meta.dirty;
        end
    end

    // the write index is the read index, the request is held
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[rd_index]  <= wr_meta.tag;
            data_q[rd_index] <= wr_line;
        end
    end

endmodule

/* cache_l2_pkg.sv */
`include "cache_l2_params.svh"

package cache_l2_pkg;

    // word address as seen from L1
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
    } l2_addr_t;

    // held by L1 until ready
    typedef struct packed {
        logic                   read;
        logic                   write;
        l2_addr_t               addr;
        logic [`L2_WORD_W-1:0]  wdata;
    } l2_req_t;

    // one line, seen flat on the memory side and as words on the L1 side
    typedef union packed {
        logic [`L2_LINE_W-1:0]                  flat;
        logic [`L2_WORDS-1:0][`L2_WORD_W-1:0]   words;
    } l2_line_u;

    // per-line state and tag
    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [`L2_TAG_W-1:0]   tag;
    } l2_meta_t;

    // line request towards memory
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [`L2_MEM_ADDR_W-1:0]  addr;
        l2_line_u                   wdata;
    } l2_mem_req_t;

endpackage

/* cache_l2_params.svh */
`ifndef CACHE_L2_PARAMS_SVH
`define CACHE_L2_PARAMS_SVH

// L1 side word address and data
`define L2_ADDR_W      30
`define L2_WORD_W      32

// address split, tag | index | offset
`define L2_OFFSET_W    2
`define L2_INDEX_W     6
`define L2_TAG_W       22

// cache geometry
`define L2_LINES       64
`define L2_WORDS       4
`define L2_LINE_W      128

// memory side moves whole lines
`define L2_MEM_ADDR_W  28

`endif
